// File: all.f
logic/exPkg.sv
logic/exDecode.sv
logic/operandForward.sv
logic/aluCore.sv
logic/pcUnit.sv
logic/executeStage.sv
tb/executeStageTb.sv

// File: Bender.yml
package:
  name: execute_stage

sources:
  # package first, then the stage blocks, top level last
  - logic/exPkg.sv
  - logic/exDecode.sv
  - logic/operandForward.sv
  - logic/aluCore.sv
  - logic/pcUnit.sv
  - logic/executeStage.sv
  - target: test
    files:
      - tb/executeStageTb.sv

// File: tb/exPatterns.hex
// ctl fwd rs rt imm pcInc | exAlu exImm exLink memAlu memImm memLink memLoad
// | expResult expNextPc expFlags(valid bit4, taken bit0) expStoreData; ffff ends
1000 0000 1234 4321 0000 0102 a001 a002 a003 b001 b002 b003 b004 5555 0102 0010 4321
1001 0000 1000 0001 0000 0104 a001 a002 a003 b001 b002 b003 b004 0fff 0104 0010 0001
1002 0000 ff00 0ff0 0000 0106 a001 a002 a003 b001 b002 b003 b004 f0f0 0106 0010 0ff0
1003 0000 f0f0 ff00 0000 0108 a001 a002 a003 b001 b002 b003 b004 00f0 0108 0010 ff00
1004 0000 8001 0004 0000 010a a001 a002 a003 b001 b002 b003 b004 0018 010a 0010 0004
1005 0000 00ff 0013 0000 010c a001 a002 a003 b001 b002 b003 b004 07f8 010c 0010 0013
1006 0000 0001 0001 0000 010e a001 a002 a003 b001 b002 b003 b004 8000 010e 0010 0001
1007 0000 8000 000f 0000 0110 a001 a002 a003 b001 b002 b003 b004 0001 0110 0010 000f
1008 0000 7fff 5a5a 0001 0112 a001 a002 a003 b001 b002 b003 b004 8000 0112 0010 5a5a
1009 0000 0000 0000 0001 0114 a001 a002 a003 b001 b002 b003 b004 ffff 0114 0010 0000
100a 0000 aaaa 0000 ffff 0116 a001 a002 a003 b001 b002 b003 b004 5555 0116 0010 0000
100b 0000 ffff 0000 000f 0118 a001 a002 a003 b001 b002 b003 b004 fff0 0118 0010 0000
100c 0000 1234 0000 0008 011a a001 a002 a003 b001 b002 b003 b004 3412 011a 0010 0000
100d 0000 0001 0000 000f 011c a001 a002 a003 b001 b002 b003 b004 8000 011c 0010 0000
100e 0000 1234 0000 0004 011e a001 a002 a003 b001 b002 b003 b004 4123 011e 0010 0000
100f 0000 ff00 0000 fff4 0120 a001 a002 a003 b001 b002 b003 b004 0ff0 0120 0010 0000
101c 0000 1111 0000 ff80 0122 a001 a002 a003 b001 b002 b003 b004 ff80 0122 0010 0000
101d 0000 12ab 0000 00cd 0124 a001 a002 a003 b001 b002 b003 b004 abcd 0124 0010 0000
1000 00aa dead 0000 0000 0126 a001 a002 a003 b001 b002 b003 b004 4002 0126 0010 a001
1000 00be dead beef 0000 0128 a001 a002 a003 b001 b002 b003 b004 5003 0128 0010 b001
1000 008f dead beef 0000 012a a001 a002 a003 b001 b002 b003 b004 5005 012a 0010 b002
1000 00ec dead beef 0000 012c a001 a002 a003 b001 b002 b003 b004 6004 012c 0010 b003
1000 00fd dead beef 0000 012e a001 a002 a003 b001 b002 b003 b004 6006 012e 0010 b004
1000 00cb dead beef 0000 0130 a001 a002 a003 b001 b002 b003 b004 5005 0130 0010 a002
1000 0008 0000 5555 0000 0134 a001 a002 a003 b001 b002 b003 b004 a003 0134 0010 a003
1010 0000 1234 1234 0000 0136 a001 a002 a003 b001 b002 b003 b004 0001 0136 0010 1234
1010 0000 1234 1235 0000 0138 a001 a002 a003 b001 b002 b003 b004 0000 0138 0010 1235
1011 0000 8000 0001 0000 013a a001 a002 a003 b001 b002 b003 b004 0001 013a 0010 0001
1011 0000 7fff ffff 0000 013c a001 a002 a003 b001 b002 b003 b004 0000 013c 0010 ffff
1012 0000 0005 0005 0000 013e a001 a002 a003 b001 b002 b003 b004 0001 013e 0010 0005
1012 0000 0006 0005 0000 0140 a001 a002 a003 b001 b002 b003 b004 0000 0140 0010 0005
1013 0000 ffff 0001 0000 0142 a001 a002 a003 b001 b002 b003 b004 0001 0142 0010 0001
1013 0000 fffe 0001 0000 0144 a001 a002 a003 b001 b002 b003 b004 0000 0144 0010 0001
1014 0000 0000 0000 0010 0146 a001 a002 a003 b001 b002 b003 b004 0000 0156 0011 0000
1014 0000 0001 0000 0010 0148 a001 a002 a003 b001 b002 b003 b004 0001 0148 0010 0000
1015 0000 0001 0000 fff0 014a a001 a002 a003 b001 b002 b003 b004 0001 013a 0011 0000
1015 0000 0000 0000 fff0 014c a001 a002 a003 b001 b002 b003 b004 0000 014c 0010 0000
1016 0000 8000 0000 0020 014e a001 a002 a003 b001 b002 b003 b004 8000 016e 0011 0000
1016 0000 7fff 0000 0020 0150 a001 a002 a003 b001 b002 b003 b004 7fff 0150 0010 0000
1017 0000 0000 0000 0004 0152 a001 a002 a003 b001 b002 b003 b004 0000 0156 0011 0000
1017 0000 ffff 0000 0004 0154 a001 a002 a003 b001 b002 b003 b004 ffff 0154 0010 0000
1018 0000 0000 0000 0100 0156 a001 a002 a003 b001 b002 b003 b004 0100 0256 0011 0000
1019 0000 2000 0000 0004 0158 a001 a002 a003 b001 b002 b003 b004 0004 2004 0011 0000
101a 0000 0000 0000 fffe 015a a001 a002 a003 b001 b002 b003 b004 015a 0158 0011 0000
101b 00d0 3000 0000 0002 015c a001 a002 a003 b001 b002 b003 b004 015c b006 0011 0000
101e 0000 1000 0000 0020 015e a001 a002 a003 b001 b002 b003 b004 1020 015e 0010 0000
111f 0000 2000 cafe fffc 0160 a001 a002 a003 b001 b002 b003 b004 1ffc 0160 0010 cafe
111f 000d 4000 cafe 0010 0162 a001 a002 a003 b001 b002 b003 b004 4010 0162 0010 b004
111f 00ad 4000 cafe 0001 0164 a001 a002 a003 b001 b002 b003 b004 a002 0164 0010 b004
0020 0000 0000 0000 0000 0166 a001 a002 a003 b001 b002 b003 b004 0000 0166 0000 0000
0000 0000 0001 0002 0000 0168 a001 a002 a003 b001 b002 b003 b004 0003 0168 0000 0002
1020 0000 1234 5678 0000 016a a001 a002 a003 b001 b002 b003 b004 0000 016a 0010 5678
ffff

// File: tb/executeStageTb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// executeStageTb: replays instruction patterns through the execute
// stage and checks each registered result one cycle later
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module executeStageTb
   import exPkg::*;
();

   // 17 hex words per pattern line, see the header of the pattern file
   localparam int fieldsPerLine = 17;
   localparam int maxLines      = 128;
   localparam int resetTimeout  = 20;

   logic      clk;
   logic      arstN;
   exInstr    instrIn;
   bypassData bypass;
   exResult   resOut;

   word patMem [0:fieldsPerLine*maxLines-1];
   int  numLines;

   executeStage UUT (
      .clk     (clk),
      .arstN   (arstN),
      .instrIn (instrIn),
      .bypass  (bypass),
      .resOut  (resOut)
   );

   // 40 ns clock
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // all inputs known from time zero, reset held for 3 cycles
   initial begin
      arstN   = 1'b0;
      instrIn = '0;
      bypass  = '0;
      repeat (3) @(posedge clk);
      arstN <= 1'b1;
   end

   // word 0: valid nibble, isStore nibble, opcode byte
   // word 1: fwdA in bits 7:4, fwdB in bits 3:0
   function automatic exInstr lineInstr(input int lineNo);
      int     base;
      exInstr instr;
      base          = lineNo * fieldsPerLine;
      instr.valid   = patMem[base][12];
      instr.isStore = patMem[base][8];
      instr.opcode  = exOpcode'(patMem[base][5:0]);
      instr.fwdA    = fwdSrc'(patMem[base+1][7:4]);
      instr.fwdB    = fwdSrc'(patMem[base+1][3:0]);
      instr.rsData  = patMem[base+2];
      instr.rtData  = patMem[base+3];
      instr.imm     = patMem[base+4];
      instr.pcInc   = patMem[base+5];
      return instr;
   endfunction

   function automatic bypassData lineBypass(input int lineNo);
      int        base;
      bypassData byp;
      base        = lineNo * fieldsPerLine;
      byp.exAlu   = patMem[base+6];
      byp.exImm   = patMem[base+7];
      byp.exLink  = patMem[base+8];
      byp.memAlu  = patMem[base+9];
      byp.memImm  = patMem[base+10];
      byp.memLink = patMem[base+11];
      byp.memLoad = patMem[base+12];
      return byp;
   endfunction

   // expected flags word: bit 4 valid, bit 0 taken
   function automatic exResult lineExpect(input int lineNo);
      int      base;
      exResult exp;
      base          = lineNo * fieldsPerLine;
      exp.result    = patMem[base+13];
      exp.nextPc    = patMem[base+14];
      exp.valid     = patMem[base+15][4];
      exp.taken     = patMem[base+15][0];
      exp.storeData = patMem[base+16];
      return exp;
   endfunction

   task automatic abortRun(input string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic checkWord(input string tag, input string name, input word got,
                            input word exp);
      if (got !== exp) begin
         abortRun($sformatf("CHECK FAILED %s %s got %h expected %h",
                            name, tag, got, exp));
      end
   endtask

   // valid and taken, the single-bit fields of the result
   task automatic checkResult(input string tag, input exResult got, input exResult exp);
      if (got.valid !== exp.valid) begin
         abortRun($sformatf("CHECK FAILED resOut.valid %s got %h expected %h",
                            tag, got.valid, exp.valid));
      end else if (got.taken !== exp.taken) begin
         abortRun($sformatf("CHECK FAILED resOut.taken %s got %h expected %h",
                            tag, got.taken, exp.taken));
      end
   endtask

   task automatic checkAll(input string tag, input exResult got, input exResult exp);
      checkResult(tag, got, exp);
      checkWord(tag, "resOut.result", got.result, exp.result);
      checkWord(tag, "resOut.nextPc", got.nextPc, exp.nextPc);
      checkWord(tag, "resOut.storeData", got.storeData, exp.storeData);
   endtask

   initial begin
      int waitCnt;
      int line;
      $readmemh("tb/exPatterns.hex", patMem);
      // count lines up to the ffff end marker
      numLines = 0;
      while (numLines < maxLines && patMem[numLines*fieldsPerLine] !== 16'hffff) begin
         if ($isunknown(patMem[numLines*fieldsPerLine])) begin
            abortRun("pattern file ends without its end marker");
         end
         numLines++;
      end
      if (numLines == 0 || numLines == maxLines) begin
         abortRun("pattern file holds no usable lines or no end marker");
      end

      // output register cleared while reset is held
      @(negedge clk);
      checkAll("during reset", resOut, '0);

      waitCnt = 0;
      while (arstN !== 1'b1) begin
         if (waitCnt == resetTimeout) begin
            abortRun("timed out waiting for reset release");
         end
         @(posedge clk);
         waitCnt++;
      end

      // one line in flight: drive line n, check line n-1 at the falling edge
      for (line = 0; line <= numLines; line++) begin
         @(posedge clk);
         if (line < numLines) begin
            instrIn <= lineInstr(line);
            bypass  <= lineBypass(line);
         end else begin
            instrIn <= '0;
            bypass  <= '0;
         end
         @(negedge clk);
         if (line == 0) begin
            checkAll("idle after reset", resOut, '0);
         end else begin
            checkAll($sformatf("pattern line %0d", line - 1), resOut,
                     lineExpect(line - 1));
         end
      end

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: logic/executeStage.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// executeStage: execute stage of the 16-bit pipeline
// forwarding, ALU and next PC, result registered after one cycle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module executeStage
   import exPkg::*;
(
   input  logic      clk,
   input  logic      arstN,
   input  exInstr    instrIn,
   input  bypassData bypass,
   output exResult   resOut
);

   exCtrl   ctrl;
   word     opA;
   word     opB;
   word     storeData;
   word     aluResult;
   aluFlags flags;
   logic    taken;
   logic    condBit;
   word     nextPc;
   word     wbValue;
   exResult resNext;

   exDecode uDecode (
      .opcode (instrIn.opcode),
      .ctrl   (ctrl)
   );

   operandForward uForward (
      .instr     (instrIn),
      .bypass    (bypass),
      .b         (ctrl.b),
      .opA       (opA),
      .opB       (opB),
      .storeData (storeData)
   );

   aluCore uAlu (
      .op    (ctrl.alu),
      .a     (opA),
      .b     (opB),
      .y     (aluResult),
      .flags (flags)
   );

   // rs base for jr/jalr is the forwarded A operand
   pcUnit uPc (
      .ctrl    (ctrl),
      .flags   (flags),
      .rs      (opA),
      .imm     (instrIn.imm),
      .pcInc   (instrIn.pcInc),
      .taken   (taken),
      .condBit (condBit),
      .nextPc  (nextPc)
   );

   // write-back priority: link, then set bit, then ALU
   always_comb begin
      if (ctrl.link) begin
         wbValue = instrIn.pcInc;
      end else if (ctrl.setOp) begin
         wbValue = {15'b0, condBit};
      end else begin
         wbValue = aluResult;
      end
   end

   assign resNext = '{instrIn.valid, wbValue, nextPc, taken, storeData};

   // bubbles pass through with valid low
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         resOut <= '0;
      end else begin
         resOut <= resNext;
      end
   end

   // a store flagged by decode must form its address as A plus imm
   assert property (@(posedge clk) disable iff (!arstN)
      (instrIn.valid && instrIn.isStore) |-> (ctrl.alu == aluAdd && ctrl.b == bImm))
      else $error("store flag on an opcode that forms no address");

endmodule

`default_nettype wire

// File: logic/pcUnit.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pcUnit: condition evaluation, branch target and next PC
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pcUnit
   import exPkg::*;
(
   input  exCtrl   ctrl,
   input  aluFlags flags,
   input  word     rs,
   input  word     imm,
   input  word     pcInc,
   output logic    taken,
   output logic    condBit,
   output word     nextPc
);

   logic lessThan;
   word  base;
   word  target;

   // signed less-than after a - b
   assign lessThan = flags.sign ^ flags.ovf;

   always_comb begin
      case (ctrl.cond)
         condAlways     : condBit = 1'b1;
         condEqz        : condBit = flags.zero;
         condNez        : condBit = ~flags.zero;
         condLtz        : condBit = lessThan;
         condGez        : condBit = ~lessThan;
         condSeq        : condBit = flags.zero;
         condSlt        : condBit = lessThan;
         condSle        : condBit = lessThan | flags.zero;
         // carry out of a + b
         condSco        : condBit = flags.carry;
         default        : condBit = 1'b0;
      endcase
   end

   // set ops only write the bit, they never redirect
   assign taken = condBit & ~ctrl.setOp;

   // jr/jalr go off rs, everything else off pcInc
   assign base   = ctrl.baseRs ? rs : pcInc;
   assign target = base + imm;
   assign nextPc = taken ? target : pcInc;

   // only unconditional jumps take rs as the target base
   always_comb begin
      if (ctrl.baseRs) begin
         assert final (ctrl.cond == condAlways)
            else $error("rs target base with condition select %0d", ctrl.cond);
      end
   end

endmodule

`default_nettype wire

// File: logic/aluCore.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// aluCore: 16-bit ALU
// shared add/subtract with carry and overflow, logic, shift, rotate
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module aluCore
   import exPkg::*;
(
   input  aluOp    op,
   input  word     a,
   input  word     b,
   output word     y,
   output aluFlags flags
);

   logic        isSub;
   word         addB;
   logic [16:0] sum;
   logic [3:0]  shAmt;
   logic [31:0] rolWide;
   logic [31:0] rorWide;

   // subtract as a + ~b + 1 so one adder covers both
   assign isSub = (op == aluSub);
   assign addB  = isSub ? ~b : b;
   assign sum   = {1'b0, a} + {1'b0, addB} + {16'b0, isSub};

   // shift amount is the low nibble of B
   assign shAmt = b[3:0];

   // rotates through a doubled word
   assign rolWide = {a, a} << shAmt;
   assign rorWide = {a, a} >> shAmt;

   always_comb begin
      case (op)
         aluAdd, aluSub : y = sum[15:0];
         aluXor         : y = a ^ b;
         aluAndn        : y = a & ~b;
         aluRol         : y = rolWide[31:16];
         aluSll         : y = a << shAmt;
         aluRor         : y = rorWide[15:0];
         aluSrl         : y = a >> shAmt;
         // slbi: old low byte moves up, imm byte fills in
         aluSlbi        : y = {a[7:0], b[7:0]};
         default        : y = b;
      endcase
   end

   // carry is not-borrow on subtract
   assign flags.carry = sum[16];
   // signed overflow: same-sign inputs, result sign differs
   assign flags.ovf   = (a[15] == addB[15]) && (sum[15] != a[15]);
   assign flags.sign  = y[15];
   assign flags.zero  = ~|y;

   // a subtract gives zero exactly when its operands are equal
   always_comb begin
      if (op == aluSub) begin
         assert final (flags.zero == (a == b))
            else $error("zero flag %b on %h minus %h", flags.zero, a, b);
      end
   end

endmodule

`default_nettype wire

// File: logic/operandForward.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// operandForward: bypass muxes for operand A, B and store data
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module operandForward
   import exPkg::*;
(
   input  exInstr    instr,
   input  bypassData bypass,
   input  bSel       b,
   output word       opA,
   output word       opB,
   output word       storeData
);

   // one bypass mux, used for both rs and rt
   function automatic word pickSrc(fwdSrc sel, word regVal, bypassData byp);
      case (sel)
         fwdExAlu   : return byp.exAlu;
         fwdExImm   : return byp.exImm;
         fwdExLink  : return byp.exLink;
         fwdMemAlu  : return byp.memAlu;
         fwdMemImm  : return byp.memImm;
         fwdMemLink : return byp.memLink;
         fwdMemLoad : return byp.memLoad;
         default    : return regVal;
      endcase
   endfunction

   // legal encodings of the forwarding word
   function automatic logic isFwdSrc(fwdSrc sel);
      case (sel)
         fwdReg, fwdExAlu, fwdExImm, fwdExLink,
         fwdMemAlu, fwdMemImm, fwdMemLink, fwdMemLoad : return 1'b1;
         default : return 1'b0;
      endcase
   endfunction

   word rtFwd;

   always_comb begin
      opA   = pickSrc(instr.fwdA, instr.rsData, bypass);
      rtFwd = pickSrc(instr.fwdB, instr.rtData, bypass);
      // stores keep rt off the ALU, it only feeds the memory write
      if (instr.isStore) begin
         opB = instr.imm;
      end else begin
         case (b)
            bReg    : opB = rtFwd;
            bImm    : opB = instr.imm;
            default : opB = '0;
         endcase
      end
   end

   assign storeData = rtFwd;

   // hazard unit must only hand over known forwarding words
   always_comb begin
      if (instr.valid) begin
         assert final (isFwdSrc(instr.fwdA) && isFwdSrc(instr.fwdB))
            else $error("illegal forwarding select A=%h B=%h", instr.fwdA, instr.fwdB);
      end
   end

endmodule

`default_nettype wire

// File: logic/exDecode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// exDecode: opcode to execute control word
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module exDecode
   import exPkg::*;
(
   input  exOpcode opcode,
   output exCtrl   ctrl
);

   // field order: alu, cond, b, baseRs, setOp, link
   always_comb begin
      case (opcode)
         // register-register
         opAdd   : ctrl = '{aluAdd,   condNever,  bReg,  1'b0, 1'b0, 1'b0};
         opSub   : ctrl = '{aluSub,   condNever,  bReg,  1'b0, 1'b0, 1'b0};
         opXor   : ctrl = '{aluXor,   condNever,  bReg,  1'b0, 1'b0, 1'b0};
         opAndn  : ctrl = '{aluAndn,  condNever,  bReg,  1'b0, 1'b0, 1'b0};
         opRol   : ctrl = '{aluRol,   condNever,  bReg,  1'b0, 1'b0, 1'b0};
         opSll   : ctrl = '{aluSll,   condNever,  bReg,  1'b0, 1'b0, 1'b0};
         opRor   : ctrl = '{aluRor,   condNever,  bReg,  1'b0, 1'b0, 1'b0};
         opSrl   : ctrl = '{aluSrl,   condNever,  bReg,  1'b0, 1'b0, 1'b0};
         // register-immediate, same ALU functions with imm as B
         opAddi  : ctrl = '{aluAdd,   condNever,  bImm,  1'b0, 1'b0, 1'b0};
         opSubi  : ctrl = '{aluSub,   condNever,  bImm,  1'b0, 1'b0, 1'b0};
         opXori  : ctrl = '{aluXor,   condNever,  bImm,  1'b0, 1'b0, 1'b0};
         opAndni : ctrl = '{aluAndn,  condNever,  bImm,  1'b0, 1'b0, 1'b0};
         opRoli  : ctrl = '{aluRol,   condNever,  bImm,  1'b0, 1'b0, 1'b0};
         opSlli  : ctrl = '{aluSll,   condNever,  bImm,  1'b0, 1'b0, 1'b0};
         opRori  : ctrl = '{aluRor,   condNever,  bImm,  1'b0, 1'b0, 1'b0};
         opSrli  : ctrl = '{aluSrl,   condNever,  bImm,  1'b0, 1'b0, 1'b0};
         // set ops write the condition bit; sco needs the add carry
         opSeq   : ctrl = '{aluSub,   condSeq,    bReg,  1'b0, 1'b1, 1'b0};
         opSlt   : ctrl = '{aluSub,   condSlt,    bReg,  1'b0, 1'b1, 1'b0};
         opSle   : ctrl = '{aluSub,   condSle,    bReg,  1'b0, 1'b1, 1'b0};
         opSco   : ctrl = '{aluAdd,   condSco,    bReg,  1'b0, 1'b1, 1'b0};
         // branches test rs minus zero, target off pcInc
         opBeqz  : ctrl = '{aluSub,   condEqz,    bZero, 1'b0, 1'b0, 1'b0};
         opBnez  : ctrl = '{aluSub,   condNez,    bZero, 1'b0, 1'b0, 1'b0};
         opBltz  : ctrl = '{aluSub,   condLtz,    bZero, 1'b0, 1'b0, 1'b0};
         opBgez  : ctrl = '{aluSub,   condGez,    bZero, 1'b0, 1'b0, 1'b0};
         // jumps, register forms take rs as base
         opJ     : ctrl = '{aluPassB, condAlways, bImm,  1'b0, 1'b0, 1'b0};
         opJr    : ctrl = '{aluPassB, condAlways, bImm,  1'b1, 1'b0, 1'b0};
         opJal   : ctrl = '{aluPassB, condAlways, bImm,  1'b0, 1'b0, 1'b1};
         opJalr  : ctrl = '{aluPassB, condAlways, bImm,  1'b1, 1'b0, 1'b1};
         // immediates and memory address generation
         opLbi   : ctrl = '{aluPassB, condNever,  bImm,  1'b0, 1'b0, 1'b0};
         opSlbi  : ctrl = '{aluSlbi,  condNever,  bImm,  1'b0, 1'b0, 1'b0};
         opLd    : ctrl = '{aluAdd,   condNever,  bImm,  1'b0, 1'b0, 1'b0};
         opSt    : ctrl = '{aluAdd,   condNever,  bImm,  1'b0, 1'b0, 1'b0};
         // nop and anything unknown: zero result, never taken
         default : ctrl = '{aluPassB, condNever,  bZero, 1'b0, 1'b0, 1'b0};
      endcase
   end

endmodule

`default_nettype wire

// File: logic/exPkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage package
// opcodes, ALU and condition selects, forwarding sources and the
// structs that carry an instruction into and out of the stage
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package exPkg;

   // data, address and PC values are all one machine word
   typedef logic [15:0] word;

   typedef enum logic [5:0] {
      opAdd, opSub, opXor, opAndn, opRol, opSll, opRor, opSrl,
      opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori, opSrli,
      opSeq, opSlt, opSle, opSco,
      opBeqz, opBnez, opBltz, opBgez,
      opJ, opJr, opJal, opJalr,
      opLbi, opSlbi, opLd, opSt, opNop
   } exOpcode;

   typedef enum logic [3:0] {
      aluAdd, aluSub, aluXor, aluAndn, aluRol,
      aluSll, aluRor, aluSrl, aluPassB, aluSlbi
   } aluOp;

   typedef enum logic [3:0] {
      condNever, condAlways, condEqz, condNez, condLtz,
      condGez, condSeq, condSlt, condSle, condSco
   } condSel;

   // bit 3 forward at all, bit 2 mem (1) or ex (0) stage,
   // bits 1:0 source: 00 link, 01 load, 10 alu, 11 immediate
   typedef enum logic [3:0] {
      fwdReg     = 4'b0000,
      fwdExAlu   = 4'b1010,
      fwdExImm   = 4'b1011,
      fwdExLink  = 4'b1000,
      fwdMemAlu  = 4'b1110,
      fwdMemImm  = 4'b1111,
      fwdMemLink = 4'b1100,
      fwdMemLoad = 4'b1101
   } fwdSrc;

   typedef enum logic [1:0] {
      bReg  = 2'd0,
      bImm  = 2'd1,
      bZero = 2'd2
   } bSel;

   typedef struct packed {
      logic    valid;
      exOpcode opcode;
      word     rsData;
      word     rtData;
      word     imm;
      word     pcInc;
      fwdSrc   fwdA;
      fwdSrc   fwdB;
      logic    isStore;
   } exInstr;

   // values still in flight in the later stages
   typedef struct packed {
      word exAlu;
      word exImm;
      word exLink;
      word memAlu;
      word memImm;
      word memLink;
      word memLoad;
   } bypassData;

   typedef struct packed {
      logic zero;
      logic sign;
      logic ovf;
      logic carry;
   } aluFlags;

   typedef struct packed {
      aluOp   alu;
      condSel cond;
      bSel    b;
      logic   baseRs;
      logic   setOp;
      logic   link;
   } exCtrl;

   typedef struct packed {
      logic valid;
      word  result;
      word  nextPc;
      logic taken;
      word  storeData;
   } exResult;

endpackage

`default_nettype wire
